// ==== src/host_ep_pkg.sv ====
`default_nettype none

////////////////////
// host endpoint map
////////////////////

package host_ep_pkg;

    // trigger vector from the host
    localparam int unsigned trig_width = 16;

    // trigger bit per parameter
    localparam int unsigned trig_pps_coef      = 1;
    localparam int unsigned trig_tau           = 2;
    localparam int unsigned trig_gain          = 3;
    localparam int unsigned trig_gamma_dyn     = 4;
    localparam int unsigned trig_gamma_sta     = 5;
    localparam int unsigned trig_gain_syn      = 6;
    localparam int unsigned trig_trigger_input = 7;
    localparam int unsigned trig_len           = 8;
    localparam int unsigned trig_velocity      = 9;
    localparam int unsigned trig_bdamp_chain   = 13;
    localparam int unsigned trig_bdamp_2       = 14;
    localparam int unsigned trig_bdamp_1       = 15;

    // reset defaults, floats as ieee-754 single
    localparam logic [31:0] def_pps_coef      = 32'h3F66_6666;
    localparam logic [31:0] def_tau           = 32'd1;
    localparam logic [31:0] def_gain          = 32'd0;
    // 80.0 for both fusimotor drives
    localparam logic [31:0] def_gamma_dyn     = 32'h42A0_0000;
    localparam logic [31:0] def_gamma_sta     = 32'h42A0_0000;
    localparam logic [31:0] def_gain_syn      = 32'd1;
    localparam logic [31:0] def_trigger_input = 32'd1;
    // 0.9 muscle length
    localparam logic [31:0] def_len           = 32'h3F66_6666;
    localparam logic [31:0] def_velocity      = 32'h0000_0000;
    // intrafusal damping, bag 1 / bag 2 / chain
    localparam logic [31:0] def_bdamp_1       = 32'h3E71_4120;
    localparam logic [31:0] def_bdamp_2       = 32'h3D14_4674;
    localparam logic [31:0] def_bdamp_chain   = 32'h3C58_44D0;

    // readout endpoints, low half here and high half one above
    localparam logic [7:0] addr_syn_current = 8'h20;
    localparam logic [7:0] addr_ia_rate     = 8'h22;
    localparam logic [7:0] addr_sn_count    = 8'h24;
    localparam logic [7:0] addr_mn_count    = 8'h26;
    localparam logic [7:0] addr_comb_count  = 8'h28;
    localparam logic [7:0] addr_force       = 8'h30;
    localparam logic [7:0] addr_len         = 8'h32;

    // full model parameter set, 12 x 32 bits
    typedef struct packed {
        logic [31:0] pps_coef;
        logic [31:0] tau;
        logic [31:0] gain;
        logic [31:0] gamma_dyn;
        logic [31:0] gamma_sta;
        logic [31:0] gain_syn;
        logic [31:0] trigger_input;
        logic [31:0] len;
        logic [31:0] velocity;
        logic [31:0] bdamp_1;
        logic [31:0] bdamp_2;
        logic [31:0] bdamp_chain;
    } model_params_t;

endpackage

`default_nettype wire

// ==== src/neuro_pkg.sv ====
`default_nettype none

////////////////////
// neural path types
////////////////////

package neuro_pkg;

    // width of every spike counter
    localparam int unsigned spk_cnt_width = 32;

    typedef logic [spk_cnt_width-1:0] spk_cnt_t;

    // window snapshots of the three counters
    typedef struct packed {
        // sensory neuron
        spk_cnt_t sn;
        // motor neuron
        spk_cnt_t mn;
        // motor neuron or cross-board spike
        spk_cnt_t comb;
    } spike_counts_t;

    ////////////////////
    // float constants
    ////////////////////

    // 1.0, rest length of the muscle model
    localparam logic [31:0] ieee_one = 32'h3F80_0000;

endpackage

`default_nettype wire

// ==== src/spike_window_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

// windowed spike counter
module spike_window_counter
    import neuro_pkg::*;
(
    input  wire                      ep50trig,
    input  wire                      reset_sim,
    input  wire                      i_spike,
    input  wire                      i_window,
    output logic [spk_cnt_width-1:0] o_count
);

    // running count inside the current window
    spk_cnt_t cnt_q;
    // count with this cycle's spike added
    spk_cnt_t cnt_next;

    assign cnt_next = cnt_q + spk_cnt_t'(i_spike);

    ////////////////////
    // running counter
    ////////////////////

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            cnt_q <= '0;
        end
        else if (i_window)
        begin
            // restart for the next window
            cnt_q <= '0;
        end
        else
        begin
            cnt_q <= cnt_next;
        end
    end

    ////////////////////
    // window snapshot
    ////////////////////

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            o_count <= '0;
        end
        else if (i_window)
        begin
            // spike on the strobe cycle still belongs to this window
            o_count <= cnt_next;
        end
    end

    // a full counter must not roll over to zero
    a_no_wrap: assert property (@(posedge ep50trig) disable iff (reset_sim)
        ((&cnt_q) && !i_window) |=> (cnt_q != '0))
        else $error("spike_window_counter: running count wrapped");

endmodule

`default_nettype wire

// ==== src/param_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

// trigger-loaded model parameters
module param_bank
    import host_ep_pkg::*;
(
    input  wire                   ep50trig,
    input  wire                   reset_sim,
    input  wire  [trig_width-1:0] i_trig,
    input  wire  [15:0]           i_wire_lo,
    input  wire  [15:0]           i_wire_hi,
    output model_params_t         o_params
);

    // host word pair, hi on top
    logic [31:0]   load_word;
    model_params_t params_q;

    assign load_word = {i_wire_hi, i_wire_lo};

    ////////////////////
    // parameter registers
    ////////////////////

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            params_q.pps_coef      <= def_pps_coef;
            params_q.tau           <= def_tau;
            params_q.gain          <= def_gain;
            params_q.gamma_dyn     <= def_gamma_dyn;
            params_q.gamma_sta     <= def_gamma_sta;
            params_q.gain_syn      <= def_gain_syn;
            params_q.trigger_input <= def_trigger_input;
            params_q.len           <= def_len;
            params_q.velocity      <= def_velocity;
            params_q.bdamp_1       <= def_bdamp_1;
            params_q.bdamp_2       <= def_bdamp_2;
            params_q.bdamp_chain   <= def_bdamp_chain;
        end
        else
        begin
            // each field waits for its own trigger bit
            if (i_trig[trig_pps_coef])
                params_q.pps_coef <= load_word;
            if (i_trig[trig_tau])
                params_q.tau <= load_word;
            if (i_trig[trig_gain])
                params_q.gain <= load_word;
            // fusimotor drive
            if (i_trig[trig_gamma_dyn])
                params_q.gamma_dyn <= load_word;
            if (i_trig[trig_gamma_sta])
                params_q.gamma_sta <= load_word;
            // integer synaptic gain
            if (i_trig[trig_gain_syn])
                params_q.gain_syn <= load_word;
            if (i_trig[trig_trigger_input])
                params_q.trigger_input <= load_word;
            // muscle kinematics
            if (i_trig[trig_len])
                params_q.len <= load_word;
            if (i_trig[trig_velocity])
                params_q.velocity <= load_word;
            // spindle damping
            if (i_trig[trig_bdamp_1])
                params_q.bdamp_1 <= load_word;
            if (i_trig[trig_bdamp_2])
                params_q.bdamp_2 <= load_word;
            if (i_trig[trig_bdamp_chain])
                params_q.bdamp_chain <= load_word;
        end
    end

    assign o_params = params_q;

    // host raises at most one trigger per cycle
    a_trig_onehot: assert property (@(posedge ep50trig) disable iff (reset_sim)
        $onehot0(i_trig))
        else $error("param_bank: more than one trigger bit %h", i_trig);

endmodule

`default_nettype wire

// ==== src/reflex_loop.sv ====
`timescale 1ns/1ps
`default_nettype none

// synaptic gain and spike counting
module reflex_loop
    import neuro_pkg::*;
(
    input  wire                 ep50trig,
    input  wire                 reset_sim,
    input  wire signed [31:0]   i_syn_current,
    input  wire        [31:0]   i_gain_syn,
    input  wire                 i_sn_spike,
    input  wire                 i_mn_spike,
    input  wire                 i_ext_spike,
    input  wire                 i_window,
    output logic       [31:0]   o_syn_scaled,
    output spike_counts_t       o_counts
);

    // low word of current x gain
    logic signed [31:0] syn_prod;
    // short latency or cross-board
    logic               comb_spike;
    spk_cnt_t           sn_count;
    spk_cnt_t           mn_count;
    spk_cnt_t           comb_count;

    ////////////////////
    // synapse gain
    ////////////////////

    // 32-bit context keeps only the low product word
    assign syn_prod = i_syn_current * $signed(i_gain_syn);

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            o_syn_scaled <= '0;
        else
            o_syn_scaled <= syn_prod;
    end

    ////////////////////
    // spike counters
    ////////////////////

    assign comb_spike = i_mn_spike | i_ext_spike;

    // sensory neuron
    spike_window_counter u_sn_cnt (
        .ep50trig  (ep50trig),
        .reset_sim (reset_sim),
        .i_spike   (i_sn_spike),
        .i_window  (i_window),
        .o_count   (sn_count)
    );

    // motor neuron
    spike_window_counter u_mn_cnt (
        .ep50trig  (ep50trig),
        .reset_sim (reset_sim),
        .i_spike   (i_mn_spike),
        .i_window  (i_window),
        .o_count   (mn_count)
    );

    // combined drive into the muscle
    spike_window_counter u_comb_cnt (
        .ep50trig  (ep50trig),
        .reset_sim (reset_sim),
        .i_spike   (comb_spike),
        .i_window  (i_window),
        .o_count   (comb_count)
    );

    assign o_counts = '{sn: sn_count, mn: mn_count, comb: comb_count};

endmodule

`default_nettype wire

// ==== src/wire_out_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

// addressed telemetry readout and leds
module wire_out_bank
    import host_ep_pkg::*;
    import neuro_pkg::*;
(
    input  wire           ep50trig,
    input  wire           reset_sim,
    input  wire  [7:0]    i_rd_addr,
    input  wire  [31:0]   i_syn_scaled,
    input  wire  [31:0]   i_ia_rate,
    input  wire  [31:0]   i_force,
    input  wire  [31:0]   i_len,
    input  spike_counts_t i_counts,
    input  wire           i_sn_spike,
    input  wire           i_mn_spike,
    input  wire           i_ext_spike,
    input  wire           i_window,
    output logic [15:0]   o_rd_data,
    output logic [3:0]    o_led
);

    // selected half before the output register
    logic [15:0] rd_mux;

    ////////////////////
    // address decode
    ////////////////////

    always_comb
    begin
        case (i_rd_addr)
            // scaled synapse current
            addr_syn_current:          rd_mux = i_syn_scaled[15:0];
            addr_syn_current + 8'd1:   rd_mux = i_syn_scaled[31:16];
            // spindle ia firing rate
            addr_ia_rate:              rd_mux = i_ia_rate[15:0];
            addr_ia_rate + 8'd1:       rd_mux = i_ia_rate[31:16];
            // window counts
            addr_sn_count:             rd_mux = i_counts.sn[15:0];
            addr_sn_count + 8'd1:      rd_mux = i_counts.sn[31:16];
            addr_mn_count:             rd_mux = i_counts.mn[15:0];
            addr_mn_count + 8'd1:      rd_mux = i_counts.mn[31:16];
            addr_comb_count:           rd_mux = i_counts.comb[15:0];
            addr_comb_count + 8'd1:    rd_mux = i_counts.comb[31:16];
            // muscle force and length
            addr_force:                rd_mux = i_force[15:0];
            addr_force + 8'd1:         rd_mux = i_force[31:16];
            addr_len:                  rd_mux = i_len[15:0];
            addr_len + 8'd1:           rd_mux = i_len[31:16];
            // unmapped endpoint
            default:                   rd_mux = 16'h0000;
        endcase
    end

    ////////////////////
    // read register
    ////////////////////

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            o_rd_data <= '0;
        else
            o_rd_data <= rd_mux;
    end

    // leds are active low
    // 0 sensory, 1 motor, 2 cross-board, 3 window
    assign o_led = ~{i_window, i_ext_spike, i_mn_spike, i_sn_spike};

endmodule

`default_nettype wire

// ==== src/reflex_host_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// reflex hub top level
module reflex_host_top
    import host_ep_pkg::*;
    import neuro_pkg::*;
(
    input  wire                   ep50trig,
    input  wire                   reset_sim,
    input  wire  [trig_width-1:0] i_trig,
    input  wire  [15:0]           i_wire_lo,
    input  wire  [15:0]           i_wire_hi,
    input  wire  signed [31:0]    i_syn_current,
    input  wire  [31:0]           i_ia_rate,
    input  wire  [31:0]           i_force,
    input  wire                   i_sn_spike,
    input  wire                   i_mn_spike,
    input  wire                   i_ext_spike,
    input  wire                   i_window,
    input  wire  [7:0]            i_rd_addr,
    output model_params_t         o_params,
    output logic [15:0]           o_rd_data,
    output logic [3:0]            o_led,
    output logic                  o_spike_out
);

    model_params_t params;
    logic [31:0]   syn_scaled;
    spike_counts_t counts;

    ////////////////////
    // input side
    ////////////////////

    param_bank u_param_bank (
        .ep50trig  (ep50trig),
        .reset_sim (reset_sim),
        .i_trig    (i_trig),
        .i_wire_lo (i_wire_lo),
        .i_wire_hi (i_wire_hi),
        .o_params  (params)
    );

    assign o_params = params;

    // processing
    reflex_loop u_reflex_loop (
        .ep50trig      (ep50trig),
        .reset_sim     (reset_sim),
        .i_syn_current (i_syn_current),
        .i_gain_syn    (params.gain_syn),
        .i_sn_spike    (i_sn_spike),
        .i_mn_spike    (i_mn_spike),
        .i_ext_spike   (i_ext_spike),
        .i_window      (i_window),
        .o_syn_scaled  (syn_scaled),
        .o_counts      (counts)
    );

    ////////////////////
    // output side
    ////////////////////

    // length readback straight from the len parameter
    wire_out_bank u_wire_out_bank (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .i_rd_addr    (i_rd_addr),
        .i_syn_scaled (syn_scaled),
        .i_ia_rate    (i_ia_rate),
        .i_force      (i_force),
        .i_len        (params.len),
        .i_counts     (counts),
        .i_sn_spike   (i_sn_spike),
        .i_mn_spike   (i_mn_spike),
        .i_ext_spike  (i_ext_spike),
        .i_window     (i_window),
        .o_rd_data    (o_rd_data),
        .o_led        (o_led)
    );

    // sensory spike to the other board
    assign o_spike_out = i_sn_spike;

endmodule

`default_nettype wire

// ==== test/tb_reflex_host.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_reflex_host
    import host_ep_pkg::*;
();

    // run length estimate, in clock cycles
    localparam int reset_cycles     = 4;
    localparam int min_spike_cycles = 8;
    localparam int max_spike_cycles = 60;
    localparam int test_cycles      = reset_cycles + 20 + 28 + 8
                                      + (max_spike_cycles + 30) + 12 + 20;
    localparam int watchdog_cycles  = 2 * test_cycles + 100;

    logic          ep50trig;
    logic          reset_sim;
    logic [15:0]   trig;
    logic [15:0]   wire_lo;
    logic [15:0]   wire_hi;
    logic [31:0]   syn_current;
    logic [31:0]   ia_rate;
    logic [31:0]   force_val;
    logic          sn_spike;
    logic          mn_spike;
    logic          ext_spike;
    logic          window;
    logic [7:0]    rd_addr;
    model_params_t params;
    logic [15:0]   rd_data;
    logic [3:0]    led;
    logic          spike_out;

    // expected parameter set
    model_params_t exp_params;
    int unsigned   seed_val;

    reflex_host_top uut (
        .ep50trig      (ep50trig),
        .reset_sim     (reset_sim),
        .i_trig        (trig),
        .i_wire_lo     (wire_lo),
        .i_wire_hi     (wire_hi),
        .i_syn_current (syn_current),
        .i_ia_rate     (ia_rate),
        .i_force       (force_val),
        .i_sn_spike    (sn_spike),
        .i_mn_spike    (mn_spike),
        .i_ext_spike   (ext_spike),
        .i_window      (window),
        .i_rd_addr     (rd_addr),
        .o_params      (params),
        .o_rd_data     (rd_data),
        .o_led         (led),
        .o_spike_out   (spike_out)
    );

    // 50 MHz
    initial
    begin
        ep50trig = 1'b0;
        forever #10 ep50trig = ~ep50trig;
    end

    ////////////////////
    // check helpers
    ////////////////////

    task automatic check32(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("Fail %s got %h expected %h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // defaults as listed for the endpoint map
    function automatic model_params_t default_params();
        model_params_t p;
        p.pps_coef      = 32'h3F66_6666;
        p.tau           = 32'h0000_0001;
        p.gain          = 32'h0000_0000;
        p.gamma_dyn     = 32'h42A0_0000;
        p.gamma_sta     = 32'h42A0_0000;
        p.gain_syn      = 32'h0000_0001;
        p.trigger_input = 32'h0000_0001;
        p.len           = 32'h3F66_6666;
        p.velocity      = 32'h0000_0000;
        p.bdamp_1       = 32'h3E71_4120;
        p.bdamp_2       = 32'h3D14_4674;
        p.bdamp_chain   = 32'h3C58_44D0;
        return p;
    endfunction

    // field expected to change for a trigger bit
    function automatic model_params_t apply_write(input model_params_t p, input int unsigned bit_num,
                                                  input logic [31:0] word);
        model_params_t q;
        q = p;
        case (bit_num)
            1:  q.pps_coef      = word;
            2:  q.tau           = word;
            3:  q.gain          = word;
            4:  q.gamma_dyn     = word;
            5:  q.gamma_sta     = word;
            6:  q.gain_syn      = word;
            7:  q.trigger_input = word;
            8:  q.len           = word;
            9:  q.velocity      = word;
            13: q.bdamp_chain   = word;
            14: q.bdamp_2       = word;
            15: q.bdamp_1       = word;
            default: q = p;
        endcase
        return q;
    endfunction

    task automatic check_params();
        check32("o_params.pps_coef", params.pps_coef, exp_params.pps_coef);
        check32("o_params.tau", params.tau, exp_params.tau);
        check32("o_params.gain", params.gain, exp_params.gain);
        check32("o_params.gamma_dyn", params.gamma_dyn, exp_params.gamma_dyn);
        check32("o_params.gamma_sta", params.gamma_sta, exp_params.gamma_sta);
        check32("o_params.gain_syn", params.gain_syn, exp_params.gain_syn);
        check32("o_params.trigger_input", params.trigger_input, exp_params.trigger_input);
        check32("o_params.len", params.len, exp_params.len);
        check32("o_params.velocity", params.velocity, exp_params.velocity);
        check32("o_params.bdamp_1", params.bdamp_1, exp_params.bdamp_1);
        check32("o_params.bdamp_2", params.bdamp_2, exp_params.bdamp_2);
        check32("o_params.bdamp_chain", params.bdamp_chain, exp_params.bdamp_chain);
    endtask

    ////////////////////
    // bus tasks
    ////////////////////

    // data is registered one edge after the address
    task automatic read_half(input logic [7:0] addr, output logic [15:0] value);
        @(posedge ep50trig);
        rd_addr <= addr;
        @(posedge ep50trig);
        @(negedge ep50trig);
        value = rd_data;
    endtask

    task automatic read_word(input logic [7:0] addr, output logic [31:0] value);
        logic [15:0] lo;
        logic [15:0] hi;
        read_half(addr, lo);
        read_half(addr + 8'd1, hi);
        value = {hi, lo};
    endtask

    task automatic check_word(input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] got;
        read_word(addr, got);
        check32($sformatf("o_rd_data[%h]", addr), got, exp);
    endtask

    // one-cycle trigger pulse, new value one cycle later
    task automatic write_param(input int unsigned bit_num, input logic [31:0] word);
        @(posedge ep50trig);
        trig    <= 16'd1 << bit_num;
        wire_lo <= word[15:0];
        wire_hi <= word[31:16];
        @(posedge ep50trig);
        trig    <= '0;
        @(negedge ep50trig);
        exp_params = apply_write(exp_params, bit_num, word);
        check_params();
    endtask

    ////////////////////
    // directed tests
    ////////////////////

    task automatic test_reset_state();
        exp_params = default_params();
        @(negedge ep50trig);
        check_params();
        check32("o_led", {28'h0, led}, 32'h0000_000F);
        check_word(addr_len, 32'h3F66_6666);
        check_word(addr_sn_count, 32'h0);
        check_word(addr_mn_count, 32'h0);
        check_word(addr_comb_count, 32'h0);
    endtask

    task automatic test_param_writes();
        int unsigned bits[12] = '{1, 2, 3, 4, 5, 6, 7, 8, 9, 13, 14, 15};
        logic [31:0] word;
        foreach (bits[i])
        begin
            word = $urandom;
            write_param(bits[i], word);
        end
        // length readback follows the written len field
        check_word(addr_len, exp_params.len);
    endtask

    task automatic test_syn_gain();
        logic [31:0] gain;
        logic [31:0] cur;
        logic [31:0] exp_prod;
        gain = $urandom;
        cur  = $urandom;
        write_param(trig_gain_syn, gain);
        @(posedge ep50trig);
        syn_current <= cur;
        // low word is the same for signed and unsigned operands
        exp_prod = cur * gain;
        check_word(addr_syn_current, exp_prod);
    endtask

    task automatic test_spike_counts();
        int          n;
        int unsigned sn_exp;
        int unsigned mn_exp;
        int unsigned comb_exp;
        logic [31:0] rnd;
        logic        ext_lvl;
        sn_exp   = 0;
        mn_exp   = 0;
        comb_exp = 0;
        ext_lvl  = 1'b0;
        n = min_spike_cycles + int'($urandom % (max_spike_cycles - min_spike_cycles + 1));
        // start from a fresh window
        @(posedge ep50trig);
        window <= 1'b1;
        @(posedge ep50trig);
        window <= 1'b0;
        for (int i = 0; i < n; i++)
        begin
            rnd = $urandom;
            // cross-board level flips every eight cycles, first at the fourth
            if ((i % 8) == 3)
                ext_lvl = ~ext_lvl;
            @(posedge ep50trig);
            sn_spike  <= rnd[0];
            mn_spike  <= rnd[1];
            ext_spike <= ext_lvl;
            // strobe lands on the last spike cycle
            window    <= (i == n - 1);
            if (rnd[0])
                sn_exp++;
            if (rnd[1])
                mn_exp++;
            if (rnd[1] || ext_lvl)
                comb_exp++;
        end
        @(posedge ep50trig);
        sn_spike  <= 1'b0;
        mn_spike  <= 1'b0;
        ext_spike <= 1'b0;
        window    <= 1'b0;
        check_word(addr_sn_count, sn_exp);
        check_word(addr_mn_count, mn_exp);
        check_word(addr_comb_count, comb_exp);
        // empty window
        @(posedge ep50trig);
        window <= 1'b1;
        @(posedge ep50trig);
        window <= 1'b0;
        check_word(addr_sn_count, 32'h0);
        check_word(addr_mn_count, 32'h0);
        check_word(addr_comb_count, 32'h0);
    endtask

    task automatic test_readout();
        logic [31:0] ia;
        logic [31:0] frc;
        logic [15:0] half;
        ia  = $urandom;
        frc = $urandom;
        @(posedge ep50trig);
        ia_rate   <= ia;
        force_val <= frc;
        check_word(addr_ia_rate, ia);
        check_word(addr_force, frc);
        // unmapped endpoint
        read_half(8'h40, half);
        check32("o_rd_data[40]", {16'h0, half}, 32'h0);
    endtask

    task automatic test_leds();
        logic [3:0] c;
        for (int i = 0; i < 16; i++)
        begin
            c = 4'(i);
            @(posedge ep50trig);
            sn_spike  <= c[0];
            mn_spike  <= c[1];
            ext_spike <= c[2];
            window    <= c[3];
            @(negedge ep50trig);
            check32("o_led", {28'h0, led}, {28'h0, ~c});
            check32("o_spike_out", {31'h0, spike_out}, {31'h0, c[0]});
        end
        @(posedge ep50trig);
        sn_spike  <= 1'b0;
        mn_spike  <= 1'b0;
        ext_spike <= 1'b0;
        window    <= 1'b0;
    endtask

    ////////////////////
    // sequence
    ////////////////////

    initial
    begin
        seed_val    = $urandom(32'h9a28);
        reset_sim   = 1'b1;
        trig        = '0;
        wire_lo     = '0;
        wire_hi     = '0;
        syn_current = '0;
        ia_rate     = '0;
        force_val   = '0;
        sn_spike    = 1'b0;
        mn_spike    = 1'b0;
        ext_spike   = 1'b0;
        window      = 1'b0;
        rd_addr     = '0;
        repeat (reset_cycles) @(posedge ep50trig);
        reset_sim <= 1'b0;
        test_reset_state();
        test_param_writes();
        test_syn_gain();
        test_spike_counts();
        test_readout();
        test_leds();
        $display("Finished with no errors");
        $finish;
    end

    // hang guard
    initial
    begin
        repeat (watchdog_cycles) @(posedge ep50trig);
        $display("watchdog expired before the tests completed");
        $display("Finished with errors");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/host_ep_pkg.sv
src/neuro_pkg.sv
src/spike_window_counter.sv
src/param_bank.sv
src/reflex_loop.sv
src/wire_out_bank.sv
src/reflex_host_top.sv
test/tb_reflex_host.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the reflex hub testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
    --top-module tb_reflex_host -o tb_reflex_host \
    || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/tb_reflex_host 2>&1)
echo "$sim_out"

echo "$sim_out" | grep -qx "Finished with no errors" \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }
